// ==== Bender.yml ====
package:
  name: alu_pipe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/alu_pipe_pkg.sv
      - hdl/alu.sv
      - hdl/alu_reg_pipeline.sv
      - hdl/prf_banked.sv
      - hdl/alu_pipe_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/alu_pipe_asserts.sv
      - verification/tb_alu_pipe_top.sv

// ==== alu_pipe_top.f ====
+incdir+hdl
hdl/alu_pipe_pkg.sv
hdl/alu.sv
hdl/alu_reg_pipeline.sv
hdl/prf_banked.sv
hdl/alu_pipe_top.sv
verification/alu_pipe_asserts.sv
verification/tb_alu_pipe_top.sv

// ==== hdl/alu.sv ====
`timescale 1ns/10ps
`include "alu_pipe_settings.svh"

module alu (
    input  alu_pipe_pkg::alu_op_t op,
    input  alu_pipe_pkg::word_t   A,
    input  alu_pipe_pkg::word_t   B,
    output alu_pipe_pkg::word_t   out
);

    localparam int SHAMT_W = $clog2(`ALU_PIPE_DATA_W);

    // shifts only look at the low bits of B
    logic [SHAMT_W-1:0] shamt;

    assign shamt = B[SHAMT_W-1:0];

    always_comb begin
        case (op)
            alu_pipe_pkg::ALU_ADD: begin
                out = A + B;
            end
            alu_pipe_pkg::ALU_SUB: begin
                out = A - B;
            end
            alu_pipe_pkg::ALU_SLL: begin
                out = A << shamt;
            end
            // signed compare
            alu_pipe_pkg::ALU_SLT: begin
                out = alu_pipe_pkg::word_t'($signed(A) < $signed(B));
            end
            // unsigned compare
            alu_pipe_pkg::ALU_SLTU: begin
                out = alu_pipe_pkg::word_t'(A < B);
            end
            alu_pipe_pkg::ALU_XOR: begin
                out = A ^ B;
            end
            alu_pipe_pkg::ALU_SRL: begin
                out = A >> shamt;
            end
            // arithmetic shift keeps the sign bit
            alu_pipe_pkg::ALU_SRA: begin
                out = alu_pipe_pkg::word_t'($signed(A) >>> shamt);
            end
            alu_pipe_pkg::ALU_OR: begin
                out = A | B;
            end
            alu_pipe_pkg::ALU_AND: begin
                out = A & B;
            end
            default: begin
                out = '0;
            end
        endcase
    end

endmodule

// ==== hdl/alu_pipe_pkg.sv ====
`include "alu_pipe_settings.svh"

package alu_pipe_pkg;

    typedef logic [`ALU_PIPE_DATA_W-1:0] word_t;
    typedef logic [$clog2(`ALU_PIPE_PR_COUNT)-1:0] pr_t;
    typedef logic [$clog2(`ALU_PIPE_PRF_BANKS)-1:0] bank_t;
    typedef logic [$clog2(`ALU_PIPE_ROB_ENTRIES)-1:0] rob_idx_t;

    // {alternate bit, funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    typedef struct packed {
        alu_op_t  op;
        logic     A_forward;
        pr_t      A_PR;
        logic     B_forward;
        pr_t      B_PR;
        pr_t      dest_PR;
        rob_idx_t ROB_index;
    } issue_pkt_t;

    typedef struct packed {
        logic A_valid;
        pr_t  A_PR;
        logic B_valid;
        pr_t  B_PR;
    } read_req_t;

    // port is the bank read port that carries the data
    typedef struct packed {
        logic A_ack;
        logic A_port;
        logic B_ack;
        logic B_port;
    } read_ack_t;

    typedef struct packed {
        word_t    data;
        pr_t      PR;
        rob_idx_t ROB_index;
    } wb_pkt_t;

    typedef struct packed {
        logic  valid;
        pr_t   PR;
        word_t data;
    } ext_write_t;

endpackage

// ==== hdl/alu_pipe_settings.svh ====
`ifndef ALU_PIPE_SETTINGS_SVH
`define ALU_PIPE_SETTINGS_SVH

// ------------------------------------------------------------
// physical register file geometry
// ------------------------------------------------------------

// total physical registers
`define ALU_PIPE_PR_COUNT 64

// banks, selected by the low tag bits
`define ALU_PIPE_PRF_BANKS 4

// ------------------------------------------------------------
// core sizing
// ------------------------------------------------------------

// reorder buffer depth
`define ALU_PIPE_ROB_ENTRIES 32

// integer datapath width
`define ALU_PIPE_DATA_W 32

`endif

// ==== hdl/alu_pipe_top.sv ====
`timescale 1ns/10ps
`include "alu_pipe_settings.svh"

module alu_pipe_top (
    input  logic CLK,
    input  logic nRST,

    // issue queue side
    input  logic                      issue_valid,
    input  alu_pipe_pkg::issue_pkt_t  issue_pkt,
    output logic                      issue_ready,

    // other functional units
    input  alu_pipe_pkg::ext_write_t  ext_write,
    input  logic                      ext_read_valid,
    input  alu_pipe_pkg::pr_t         ext_read_PR,
    output alu_pipe_pkg::word_t       ext_read_data,

    // completions to the reorder buffer
    output logic                      complete_valid,
    output alu_pipe_pkg::rob_idx_t    complete_rob,
    output alu_pipe_pkg::word_t       complete_data
);

    logic                     read_req_valid;
    alu_pipe_pkg::read_req_t  read_req;
    alu_pipe_pkg::read_ack_t  read_ack;
    alu_pipe_pkg::word_t [`ALU_PIPE_PRF_BANKS-1:0][1:0] reg_read_data_by_bank_by_port;
    alu_pipe_pkg::word_t [`ALU_PIPE_PRF_BANKS-1:0]      forward_data_by_bank;
    logic                     wb_valid;
    alu_pipe_pkg::wb_pkt_t    wb_pkt;
    logic                     wb_ready;

    alu_reg_pipeline pipe0 (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .issue_valid                   (issue_valid),
        .issue_pkt                     (issue_pkt),
        .issue_ready                   (issue_ready),
        .read_req_valid                (read_req_valid),
        .read_req                      (read_req),
        .read_ack                      (read_ack),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .wb_valid                      (wb_valid),
        .wb_pkt                        (wb_pkt),
        .wb_ready                      (wb_ready)
    );

    prf_banked prf0 (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .read_req_valid                (read_req_valid),
        .read_req                      (read_req),
        .read_ack                      (read_ack),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .wb_valid                      (wb_valid),
        .wb_pkt                        (wb_pkt),
        .wb_ready                      (wb_ready),
        .ext_write                     (ext_write),
        .ext_read_valid                (ext_read_valid),
        .ext_read_PR                   (ext_read_PR),
        .ext_read_data                 (ext_read_data)
    );

    // a completion is a writeback the register file accepted
    assign complete_valid = wb_valid & wb_ready;
    assign complete_rob   = wb_pkt.ROB_index;
    assign complete_data  = wb_pkt.data;

endmodule

// ==== hdl/alu_reg_pipeline.sv ====
`timescale 1ns/10ps
`include "alu_pipe_settings.svh"

module alu_reg_pipeline (
    input  logic CLK,
    input  logic nRST,

    // issue from the issue queue
    input  logic                      issue_valid,
    input  alu_pipe_pkg::issue_pkt_t  issue_pkt,
    output logic                      issue_ready,

    // operand reads from the register file
    output logic                      read_req_valid,
    output alu_pipe_pkg::read_req_t   read_req,
    input  alu_pipe_pkg::read_ack_t   read_ack,
    input  alu_pipe_pkg::word_t [`ALU_PIPE_PRF_BANKS-1:0][1:0] reg_read_data_by_bank_by_port,

    // word being written into each bank this cycle
    input  alu_pipe_pkg::word_t [`ALU_PIPE_PRF_BANKS-1:0]      forward_data_by_bank,

    // writeback to the register file
    output logic                      wb_valid,
    output alu_pipe_pkg::wb_pkt_t     wb_pkt,
    input  logic                      wb_ready
);

    // ------------------------------------------------------------
    // stall control
    // ------------------------------------------------------------

    logic stall_wb;
    logic stall_ex;
    logic stall_oc;

    // OC stage
    logic                     oc_valid;
    alu_pipe_pkg::issue_pkt_t oc_pkt;
    logic                     oc_a_saved;
    logic                     oc_a_fwd;
    logic                     oc_b_saved;
    logic                     oc_b_fwd;
    alu_pipe_pkg::word_t      oc_a_data;
    alu_pipe_pkg::word_t      oc_b_data;
    alu_pipe_pkg::bank_t      oc_a_bank;
    alu_pipe_pkg::bank_t      oc_b_bank;
    logic                     a_present;
    logic                     b_present;
    logic                     launch_oc;
    alu_pipe_pkg::word_t      next_a;
    alu_pipe_pkg::word_t      next_b;

    // EX stage
    logic                     ex_valid;
    alu_pipe_pkg::alu_op_t    ex_op;
    alu_pipe_pkg::word_t      ex_a;
    alu_pipe_pkg::word_t      ex_b;
    alu_pipe_pkg::pr_t        ex_dest_pr;
    alu_pipe_pkg::rob_idx_t   ex_rob;
    alu_pipe_pkg::word_t      alu_out;

    assign stall_wb = wb_valid & ~wb_ready;
    assign stall_ex = ex_valid & stall_wb;
    // OC only has to hold when it has something in it
    assign stall_oc = stall_ex & oc_valid;

    // ------------------------------------------------------------
    // issue and read request
    // ------------------------------------------------------------

    assign read_req_valid   = issue_valid & issue_ready;
    assign read_req.A_valid = ~issue_pkt.A_forward;
    assign read_req.A_PR    = issue_pkt.A_PR;
    assign read_req.B_valid = ~issue_pkt.B_forward;
    assign read_req.B_PR    = issue_pkt.B_PR;

    // ------------------------------------------------------------
    // OC stage
    // ------------------------------------------------------------

    assign oc_a_bank = alu_pipe_pkg::bank_t'(oc_pkt.A_PR);
    assign oc_b_bank = alu_pipe_pkg::bank_t'(oc_pkt.B_PR);

    assign a_present = oc_a_saved | oc_a_fwd | read_ack.A_ack;
    assign b_present = oc_b_saved | oc_b_fwd | read_ack.B_ack;

    assign launch_oc   = ~stall_oc & a_present & b_present;
    assign issue_ready = ~oc_valid | launch_oc;

    // operand select: saved copy, then forward, then read port
    always_comb begin
        if (oc_a_saved) begin
            next_a = oc_a_data;
        end else if (oc_a_fwd) begin
            next_a = forward_data_by_bank[oc_a_bank];
        end else begin
            next_a = reg_read_data_by_bank_by_port[oc_a_bank][read_ack.A_port];
        end

        if (oc_b_saved) begin
            next_b = oc_b_data;
        end else if (oc_b_fwd) begin
            next_b = forward_data_by_bank[oc_b_bank];
        end else begin
            next_b = reg_read_data_by_bank_by_port[oc_b_bank][read_ack.B_port];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            oc_valid   <= 1'b0;
            oc_a_saved <= 1'b0;
            oc_a_fwd   <= 1'b0;
            oc_b_saved <= 1'b0;
            oc_b_fwd   <= 1'b0;
        end else if (issue_ready) begin
            oc_valid   <= issue_valid;
            oc_a_saved <= 1'b0;
            oc_a_fwd   <= issue_pkt.A_forward;
            oc_b_saved <= 1'b0;
            oc_b_fwd   <= issue_pkt.B_forward;
        end else begin
            // forward is only valid for one cycle, keep what arrived
            oc_a_saved <= a_present;
            oc_a_fwd   <= 1'b0;
            oc_b_saved <= b_present;
            oc_b_fwd   <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            oc_pkt <= issue_pkt;
        end
        oc_a_data <= next_a;
        oc_b_data <= next_b;
    end

    // ------------------------------------------------------------
    // EX stage
    // ------------------------------------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            ex_valid <= 1'b0;
        end else if (~stall_ex) begin
            ex_valid <= oc_valid & launch_oc;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_ex) begin
            ex_op      <= oc_pkt.op;
            ex_a       <= next_a;
            ex_b       <= next_b;
            ex_dest_pr <= oc_pkt.dest_PR;
            ex_rob     <= oc_pkt.ROB_index;
        end
    end

    alu alu0 (
        .op  (ex_op),
        .A   (ex_a),
        .B   (ex_b),
        .out (alu_out)
    );

    // ------------------------------------------------------------
    // WB stage
    // ------------------------------------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            wb_valid <= 1'b0;
        end else if (~stall_wb) begin
            wb_valid <= ex_valid;
        end
    end

    // held steady while the register file refuses the write
    always_ff @(posedge CLK) begin
        if (~stall_wb) begin
            wb_pkt.data      <= alu_out;
            wb_pkt.PR        <= ex_dest_pr;
            wb_pkt.ROB_index <= ex_rob;
        end
    end

endmodule

// ==== hdl/prf_banked.sv ====
`timescale 1ns/10ps
`include "alu_pipe_settings.svh"

module prf_banked (
    input  logic CLK,
    input  logic nRST,

    // operand reads from the pipeline
    input  logic                      read_req_valid,
    input  alu_pipe_pkg::read_req_t   read_req,
    output alu_pipe_pkg::read_ack_t   read_ack,
    output alu_pipe_pkg::word_t [`ALU_PIPE_PRF_BANKS-1:0][1:0] reg_read_data_by_bank_by_port,
    output alu_pipe_pkg::word_t [`ALU_PIPE_PRF_BANKS-1:0]      forward_data_by_bank,

    // pipeline writeback
    input  logic                      wb_valid,
    input  alu_pipe_pkg::wb_pkt_t     wb_pkt,
    output logic                      wb_ready,

    // other functional units
    input  alu_pipe_pkg::ext_write_t  ext_write,
    input  logic                      ext_read_valid,
    input  alu_pipe_pkg::pr_t         ext_read_PR,
    output alu_pipe_pkg::word_t       ext_read_data
);

    localparam int BANKS  = `ALU_PIPE_PRF_BANKS;
    localparam int BANK_W = $bits(alu_pipe_pkg::bank_t);
    localparam int ROWS   = `ALU_PIPE_PR_COUNT / `ALU_PIPE_PRF_BANKS;
    localparam int ROW_W  = $clog2(ROWS);

    alu_pipe_pkg::word_t mem [BANKS][ROWS];

    logic                pend_a;
    logic                pend_b;
    alu_pipe_pkg::pr_t   pend_a_pr;
    alu_pipe_pkg::pr_t   pend_b_pr;
    alu_pipe_pkg::bank_t pend_a_bank;
    alu_pipe_pkg::bank_t pend_b_bank;
    alu_pipe_pkg::bank_t ext_bank;
    alu_pipe_pkg::bank_t ext_wr_bank;
    alu_pipe_pkg::bank_t wb_bank;
    logic [1:0]          b_before;
    logic [ROW_W-1:0]    port_row [BANKS][2];
    logic [BANKS-1:0]    wr_en;
    logic [ROW_W-1:0]    wr_row [BANKS];

    assign pend_a_bank = alu_pipe_pkg::bank_t'(pend_a_pr);
    assign pend_b_bank = alu_pipe_pkg::bank_t'(pend_b_pr);
    assign ext_bank    = alu_pipe_pkg::bank_t'(ext_read_PR);
    assign ext_wr_bank = alu_pipe_pkg::bank_t'(ext_write.PR);
    assign wb_bank     = alu_pipe_pkg::bank_t'(wb_pkt.PR);

    // ------------------------------------------------------------
    // read port arbitration
    // ------------------------------------------------------------

    // priority: external read, operand A, operand B
    // A always finds a free port, B may be third in its bank
    assign b_before = 2'(ext_read_valid & (ext_bank == pend_b_bank))
                    + 2'(pend_a & (pend_a_bank == pend_b_bank));

    assign read_ack.A_ack  = pend_a;
    assign read_ack.A_port = ext_read_valid & (ext_bank == pend_a_bank);
    assign read_ack.B_ack  = pend_b & (b_before != 2'd2);
    assign read_ack.B_port = b_before[0];

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            port_row[b][0] = '0;
            port_row[b][1] = '0;
            if (ext_read_valid && ext_bank == b) begin
                port_row[b][0] = ext_read_PR[BANK_W +: ROW_W];
            end
            if (read_ack.A_ack && pend_a_bank == b) begin
                port_row[b][read_ack.A_port] = pend_a_pr[BANK_W +: ROW_W];
            end
            if (read_ack.B_ack && pend_b_bank == b) begin
                port_row[b][read_ack.B_port] = pend_b_pr[BANK_W +: ROW_W];
            end
        end
    end

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            for (int p = 0; p < 2; p++) begin
                reg_read_data_by_bank_by_port[b][p] = mem[b][port_row[b][p]];
            end
        end
    end

    assign ext_read_data = reg_read_data_by_bank_by_port[ext_bank][0];

    // losers stay pending until granted
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            pend_a <= 1'b0;
            pend_b <= 1'b0;
        end else if (read_req_valid) begin
            pend_a <= read_req.A_valid;
            pend_b <= read_req.B_valid;
        end else begin
            pend_a <= pend_a & ~read_ack.A_ack;
            pend_b <= pend_b & ~read_ack.B_ack;
        end
    end

    always_ff @(posedge CLK) begin
        if (read_req_valid) begin
            pend_a_pr <= read_req.A_PR;
            pend_b_pr <= read_req.B_PR;
        end
    end

    // ------------------------------------------------------------
    // write port arbitration
    // ------------------------------------------------------------

    // external write wins its bank
    assign wb_ready = ~(ext_write.valid & (ext_wr_bank == wb_bank));

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            wr_en[b]                = 1'b0;
            wr_row[b]               = '0;
            forward_data_by_bank[b] = '0;
            if (ext_write.valid && ext_wr_bank == b) begin
                wr_en[b]                = 1'b1;
                wr_row[b]               = ext_write.PR[BANK_W +: ROW_W];
                forward_data_by_bank[b] = ext_write.data;
            end else if (wb_valid && wb_bank == b) begin
                wr_en[b]                = 1'b1;
                wr_row[b]               = wb_pkt.PR[BANK_W +: ROW_W];
                forward_data_by_bank[b] = wb_pkt.data;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int b = 0; b < BANKS; b++) begin
                for (int r = 0; r < ROWS; r++) begin
                    mem[b][r] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < BANKS; b++) begin
                if (wr_en[b]) begin
                    mem[b][wr_row[b]] <= forward_data_by_bank[b];
                end
            end
        end
    end

endmodule

// ==== verification/alu_pipe_asserts.sv ====
`timescale 1ns/10ps

module alu_pipe_asserts (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  read_req_valid,
    input logic                  oc_valid,
    input logic                  wb_valid,
    input alu_pipe_pkg::wb_pkt_t wb_pkt,
    input logic                  wb_ready
);

    // number of failed assertions
    int fails = 0;

    // refused writeback holds its packet
    wb_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_pkt)))
    else begin
        fails++;
        $error("wb_pkt changed while the writeback was refused");
    end

    wb_reset: assert property (@(posedge CLK) !nRST |-> !wb_valid)
    else begin
        fails++;
        $error("wb_valid high during reset");
    end

    // a read request belongs to an issue that OC takes in
    req_on_issue: assert property (@(posedge CLK) disable iff (!nRST)
        read_req_valid |=> oc_valid)
    else begin
        fails++;
        $error("read request without an accepted issue");
    end

endmodule

bind alu_reg_pipeline alu_pipe_asserts asserts0 (
    .CLK            (CLK),
    .nRST           (nRST),
    .read_req_valid (read_req_valid),
    .oc_valid       (oc_valid),
    .wb_valid       (wb_valid),
    .wb_pkt         (wb_pkt),
    .wb_ready       (wb_ready)
);

// ==== verification/tb_alu_pipe_top.sv ====
`timescale 1ns/10ps
`include "alu_pipe_settings.svh"

module tb_alu_pipe_top;

    localparam int TIMEOUT = 40;

    // one operation waiting for its completion
    typedef struct packed {
        alu_pipe_pkg::rob_idx_t rob;
        alu_pipe_pkg::word_t    data;
        alu_pipe_pkg::pr_t      dest;
        logic [31:0]            accept_cyc;
        logic                   fixed_latency;
    } expect_t;

    logic                     CLK;
    logic                     nRST;
    logic                     issue_valid;
    alu_pipe_pkg::issue_pkt_t issue_pkt;
    logic                     issue_ready;
    alu_pipe_pkg::ext_write_t ext_write;
    logic                     ext_read_valid;
    alu_pipe_pkg::pr_t        ext_read_PR;
    alu_pipe_pkg::word_t      ext_read_data;
    logic                     complete_valid;
    alu_pipe_pkg::rob_idx_t   complete_rob;
    alu_pipe_pkg::word_t      complete_data;

    alu_pipe_pkg::word_t    model [`ALU_PIPE_PR_COUNT];
    alu_pipe_pkg::alu_op_t  op_list [10];
    expect_t                exp_q [$];
    logic [31:0]            rng;
    int                     cyc;
    int                     value_errors;
    int                     other_errors;
    int                     completions;
    int                     last_latency;
    bit                     saw_stall;
    alu_pipe_pkg::rob_idx_t rob_next;

    alu_pipe_top dut0 (
        .CLK            (CLK),
        .nRST           (nRST),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt),
        .issue_ready    (issue_ready),
        .ext_write      (ext_write),
        .ext_read_valid (ext_read_valid),
        .ext_read_PR    (ext_read_PR),
        .ext_read_data  (ext_read_data),
        .complete_valid (complete_valid),
        .complete_rob   (complete_rob),
        .complete_data  (complete_data)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // reference ALU behaviour
    function automatic alu_pipe_pkg::word_t expected_result(input alu_pipe_pkg::alu_op_t op,
            input alu_pipe_pkg::word_t a, input alu_pipe_pkg::word_t b);
        case (op)
            alu_pipe_pkg::ALU_ADD:  return a + b;
            alu_pipe_pkg::ALU_SUB:  return a - b;
            alu_pipe_pkg::ALU_SLL:  return a << b[4:0];
            alu_pipe_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_pipe_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            alu_pipe_pkg::ALU_XOR:  return a ^ b;
            alu_pipe_pkg::ALU_SRL:  return a >> b[4:0];
            alu_pipe_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            alu_pipe_pkg::ALU_OR:   return a | b;
            alu_pipe_pkg::ALU_AND:  return a & b;
            default:                return 32'hx;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] want);
        assert (got === want) else begin
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("[ERROR] t=%0t %s", $time, what);
            other_errors++;
        end
    endtask

    // completion watcher, acts as the reorder buffer
    always @(negedge CLK) begin : completion_watch
        expect_t e;
        #2;
        if (nRST && complete_valid) begin
            completions++;
            check_true(exp_q.size() != 0, "completion with no operation in flight");
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_value("complete_rob", complete_rob, e.rob);
                check_value("complete_data", complete_data, e.data);
                last_latency = cyc + 1 - e.accept_cyc;
                if (e.fixed_latency) begin
                    check_value("completion latency", last_latency, 3);
                end
                model[e.dest] = e.data;
            end
        end
    end

    task automatic write_reg(input alu_pipe_pkg::pr_t pr, input alu_pipe_pkg::word_t data);
        ext_write.valid = 1'b1;
        ext_write.PR    = pr;
        ext_write.data  = data;
        model[pr]       = data;
    endtask

    task automatic write_idle();
        ext_write.valid = 1'b0;
    endtask

    task automatic idle();
        @(negedge CLK);
        issue_valid = 1'b0;
    endtask

    // drives one issue and waits for acceptance, leaves issue_valid high
    task automatic issue_op(input alu_pipe_pkg::alu_op_t op, input alu_pipe_pkg::pr_t a_pr,
            input alu_pipe_pkg::pr_t b_pr, input alu_pipe_pkg::pr_t dest, input logic a_fwd,
            input logic b_fwd, input alu_pipe_pkg::word_t fwd_data, input logic fixed_latency);
        alu_pipe_pkg::issue_pkt_t pkt;
        expect_t                  e;
        alu_pipe_pkg::word_t      a_val;
        alu_pipe_pkg::word_t      b_val;
        int                       n;
        pkt.op        = op;
        pkt.A_forward = a_fwd;
        pkt.A_PR      = a_pr;
        pkt.B_forward = b_fwd;
        pkt.B_PR      = b_pr;
        pkt.dest_PR   = dest;
        pkt.ROB_index = rob_next;
        @(negedge CLK);
        issue_valid = 1'b1;
        issue_pkt   = pkt;
        #2;
        n = 0;
        while (!issue_ready && n < TIMEOUT) begin
            saw_stall = 1'b1;
            @(negedge CLK);
            #2;
            n++;
        end
        check_true(issue_ready, "timeout waiting for issue_ready");
        if (issue_ready) begin
            a_val = a_fwd ? fwd_data : model[a_pr];
            b_val = b_fwd ? fwd_data : model[b_pr];
            e.rob           = rob_next;
            e.data          = expected_result(op, a_val, b_val);
            e.dest          = dest;
            e.accept_cyc    = cyc + 1;
            e.fixed_latency = fixed_latency;
            exp_q.push_back(e);
            rob_next++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(negedge CLK);
            #3;
            n++;
        end
        check_true(exp_q.size() == 0, "timeout waiting for outstanding completions");
        exp_q.delete();
    endtask

    task automatic read_check(input alu_pipe_pkg::pr_t pr);
        @(negedge CLK);
        ext_read_valid = 1'b1;
        ext_read_PR    = pr;
        #2;
        check_value("ext_read_data", ext_read_data, model[pr]);
        @(negedge CLK);
        ext_read_valid = 1'b0;
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------

    task automatic preload();
        for (int i = 0; i < 32; i++) begin
            @(negedge CLK);
            write_reg(alu_pipe_pkg::pr_t'(i), xorshift32());
        end
        @(negedge CLK);
        write_idle();
    endtask

    task automatic test_operations();
        alu_pipe_pkg::pr_t a;
        alu_pipe_pkg::pr_t b;
        alu_pipe_pkg::pr_t dest;
        for (int i = 0; i < 10; i++) begin
            a    = alu_pipe_pkg::pr_t'(xorshift32() % 32);
            b    = alu_pipe_pkg::pr_t'(xorshift32() % 32);
            dest = alu_pipe_pkg::pr_t'(32 + i);
            issue_op(op_list[i], a, b, dest, 1'b0, 1'b0, '0, 1'b1);
            idle();
            drain();
            read_check(dest);
        end
    endtask

    // source written by another unit in the cycle after acceptance
    task automatic forward_op(input alu_pipe_pkg::alu_op_t op, input alu_pipe_pkg::pr_t a_pr,
            input alu_pipe_pkg::pr_t b_pr, input logic a_fwd, input logic b_fwd,
            input alu_pipe_pkg::pr_t dest);
        alu_pipe_pkg::word_t data;
        data = xorshift32();
        issue_op(op, a_pr, b_pr, dest, a_fwd, b_fwd, data, 1'b1);
        @(negedge CLK);
        issue_valid = 1'b0;
        write_reg(a_fwd ? a_pr : b_pr, data);
        @(negedge CLK);
        write_idle();
        drain();
        read_check(dest);
    endtask

    task automatic test_forwarding();
        forward_op(alu_pipe_pkg::ALU_ADD, 6'd5, 6'd9, 1'b1, 1'b0, 6'd42);
        forward_op(alu_pipe_pkg::ALU_SUB, 6'd6, 6'd10, 1'b0, 1'b1, 6'd43);
        // both operands from the same write
        forward_op(alu_pipe_pkg::ALU_XOR, 6'd7, 6'd7, 1'b1, 1'b1, 6'd44);
    endtask

    task automatic test_contention();
        @(negedge CLK);
        ext_read_valid = 1'b1;
        ext_read_PR    = 6'd2;
        // registers 6 and 10 share bank 2 with the external read
        issue_op(alu_pipe_pkg::ALU_SUB, 6'd6, 6'd10, 6'd50, 1'b0, 1'b0, '0, 1'b0);
        idle();
        drain();
        check_value("ext_read_data", ext_read_data, model[2]);
        @(negedge CLK);
        ext_read_valid = 1'b0;
        check_true(last_latency > 3, "read port contention did not delay the completion");
        read_check(6'd50);
    endtask

    task automatic test_backpressure();
        alu_pipe_pkg::pr_t src_a [6];
        alu_pipe_pkg::pr_t src_b [6];
        int                start;
        for (int i = 0; i < 6; i++) begin
            src_a[i] = alu_pipe_pkg::pr_t'(xorshift32() % 32);
            src_b[i] = alu_pipe_pkg::pr_t'(xorshift32() % 32);
        end
        saw_stall = 1'b0;
        start     = completions;
        fork
            begin
                // all destinations in bank 1
                for (int i = 0; i < 6; i++) begin
                    issue_op(op_list[i], src_a[i], src_b[i], alu_pipe_pkg::pr_t'(33 + 4 * i),
                             1'b0, 1'b0, '0, 1'b0);
                end
                idle();
            end
            begin
                repeat (4) @(negedge CLK);
                for (int i = 0; i < 4; i++) begin
                    write_reg(6'd61, 32'h5a5a_0000 + i);
                    @(negedge CLK);
                end
                write_idle();
            end
        join
        drain();
        check_true(completions - start == 6, "completion count differs from issue count");
        check_true(saw_stall, "issue_ready never fell during the writeback stall");
    endtask

    task automatic test_streaming();
        alu_pipe_pkg::pr_t a;
        alu_pipe_pkg::pr_t b;
        alu_pipe_pkg::pr_t dest;
        for (int i = 0; i < 20; i++) begin
            a    = alu_pipe_pkg::pr_t'(xorshift32() % 32);
            b    = alu_pipe_pkg::pr_t'(xorshift32() % 32);
            dest = alu_pipe_pkg::pr_t'(32 + xorshift32() % 32);
            issue_op(op_list[xorshift32() % 10], a, b, dest, 1'b0, 1'b0, '0, 1'b1);
        end
        idle();
        drain();
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        nRST           = 1'b0;
        issue_valid    = 1'b0;
        issue_pkt      = '0;
        ext_write      = '0;
        ext_read_valid = 1'b0;
        ext_read_PR    = '0;
        rng            = 32'hf915;
        cyc            = 0;
        value_errors   = 0;
        other_errors   = 0;
        completions    = 0;
        last_latency   = 0;
        saw_stall      = 1'b0;
        rob_next       = '0;
        for (int i = 0; i < `ALU_PIPE_PR_COUNT; i++) begin
            model[i] = '0;
        end
        op_list[0] = alu_pipe_pkg::ALU_ADD;
        op_list[1] = alu_pipe_pkg::ALU_SUB;
        op_list[2] = alu_pipe_pkg::ALU_SLL;
        op_list[3] = alu_pipe_pkg::ALU_SLT;
        op_list[4] = alu_pipe_pkg::ALU_SLTU;
        op_list[5] = alu_pipe_pkg::ALU_XOR;
        op_list[6] = alu_pipe_pkg::ALU_SRL;
        op_list[7] = alu_pipe_pkg::ALU_SRA;
        op_list[8] = alu_pipe_pkg::ALU_OR;
        op_list[9] = alu_pipe_pkg::ALU_AND;

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        preload();
        test_operations();
        test_forwarding();
        test_contention();
        test_backpressure();
        test_streaming();
        repeat (4) @(negedge CLK);

        other_errors += dut0.pipe0.asserts0.fails;
        $display("error counts: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
